//--- dmem_pkg.sv
`default_nettype none

package dmem_pkg;

    // ========================================
    // data path widths
    // ========================================

    // full data word.
    localparam int DATA_W = 32;

    // byte lanes per word, one bank each.
    localparam int LANES = 4;

    // width of one lane.
    localparam int BYTE_W = DATA_W / LANES;

    // a halfword spans two lanes.
    localparam int HALF_W = 2 * BYTE_W;

    // opcode field width.
    localparam int OP_W = 3;

    // ========================================
    // access opcodes
    // ========================================

    // size and extension of an access.
    // stores ignore the signed/unsigned split.
    // codes 5 to 7 are unused and do nothing.
    typedef enum logic [OP_W-1:0] {
        DM_OP_WD = 3'd0,
        DM_OP_HS = 3'd1,
        DM_OP_HU = 3'd2,
        DM_OP_BS = 3'd3,
        DM_OP_BU = 3'd4
    } dmem_op_e;

endpackage

`default_nettype wire

//--- store_lane_gen.sv
`default_nettype none

module store_lane_gen #(
    parameter int ADDR_BITS = 10
) (
    input  logic                                en,
    input  logic                                we,
    input  dmem_pkg::dmem_op_e                  op,
    input  logic [ADDR_BITS-1:0]                addr,
    input  logic [dmem_pkg::DATA_W-1:0]         wdata,
    output logic [dmem_pkg::LANES-1:0]          lane_we,
    output logic [dmem_pkg::DATA_W-1:0]         lane_wdata,
    output logic                                misalign
);

    localparam int BW = dmem_pkg::BYTE_W;
    localparam int HW = dmem_pkg::HALF_W;

    logic [1:0]                     byte_off;
    logic [dmem_pkg::LANES-1:0]     lane_sel;

    assign byte_off = addr[1:0];

    // ========================================
    // lane selection and data placement
    // ========================================

    always_comb begin
        lane_sel   = '0;
        lane_wdata = '0;
        misalign   = 1'b0;
        case (op)
            dmem_pkg::DM_OP_WD: begin
                misalign   = (byte_off != 2'd0);
                lane_sel   = '1;
                lane_wdata = wdata;
            end
            dmem_pkg::DM_OP_HS, dmem_pkg::DM_OP_HU: begin
                // halfword sits in lanes 1:0 or 3:2.
                misalign   = byte_off[0];
                lane_sel   = byte_off[1] ? 4'b1100 : 4'b0011;
                lane_wdata = {2{wdata[HW-1:0]}};
            end
            dmem_pkg::DM_OP_BS, dmem_pkg::DM_OP_BU: begin
                lane_sel   = 4'b0001 << byte_off;
                lane_wdata = {dmem_pkg::LANES{wdata[BW-1:0]}};
            end
            default: begin
                // unused opcode, no lanes touched.
                lane_sel = '0;
            end
        endcase
    end

    // only an enabled, aligned store reaches the banks.
    assign lane_we = (en && we && !misalign) ? lane_sel : '0;

endmodule

`default_nettype wire

//--- byte_lane_ram.sv
`default_nettype none

module byte_lane_ram #(
    parameter int ADDR_BITS = 10
) (
    input  logic                            clk,
    input  logic [dmem_pkg::LANES-1:0]      lane_we,
    input  logic [dmem_pkg::DATA_W-1:0]     lane_wdata,
    input  logic [ADDR_BITS-3:0]            waddr,
    input  logic [ADDR_BITS-3:0]            addr_dbg,
    output logic [dmem_pkg::DATA_W-1:0]     rword,
    output logic [dmem_pkg::DATA_W-1:0]     data_dbg
);

    localparam int BW    = dmem_pkg::BYTE_W;
    localparam int WORDS = 1 << (ADDR_BITS - 2);

    // ========================================
    // one bank per byte lane
    // ========================================

    for (genvar i = 0; i < dmem_pkg::LANES; i++) begin : g_lane
        logic [BW-1:0] bank [WORDS];

        always_ff @(posedge clk) begin
            if (lane_we[i]) begin
                bank[waddr] <= lane_wdata[i*BW +: BW];
            end
        end

        // both reads are asynchronous, lane i lands in byte i.
        assign rword[i*BW +: BW]    = bank[waddr];
        assign data_dbg[i*BW +: BW] = bank[addr_dbg];
    end

endmodule

`default_nettype wire

//--- load_extract.sv
`default_nettype none

module load_extract (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            en,
    input  logic                            we,
    input  dmem_pkg::dmem_op_e              op,
    input  logic [1:0]                      byte_off,
    input  logic [dmem_pkg::DATA_W-1:0]     rword,
    input  logic                            misalign,
    output logic [dmem_pkg::DATA_W-1:0]     rdata,
    output logic                            rdata_valid,
    output logic                            rmisalign
);

    localparam int DW = dmem_pkg::DATA_W;
    localparam int BW = dmem_pkg::BYTE_W;
    localparam int HW = dmem_pkg::HALF_W;

    logic [BW-1:0]  sel_byte;
    logic [HW-1:0]  sel_half;
    logic [DW-1:0]  load_val;
    logic           load_req;

    assign load_req = en && !we;

    // ========================================
    // lane pick and extension
    // ========================================

    always_comb begin
        sel_byte = rword[byte_off*BW +: BW];
        sel_half = byte_off[1] ? rword[DW-1 -: HW] : rword[HW-1:0];
        case (op)
            dmem_pkg::DM_OP_WD: load_val = rword;
            dmem_pkg::DM_OP_HS: load_val = {{(DW-HW){sel_half[HW-1]}}, sel_half};
            dmem_pkg::DM_OP_HU: load_val = {{(DW-HW){1'b0}}, sel_half};
            dmem_pkg::DM_OP_BS: load_val = {{(DW-BW){sel_byte[BW-1]}}, sel_byte};
            dmem_pkg::DM_OP_BU: load_val = {{(DW-BW){1'b0}}, sel_byte};
            default:            load_val = '0;
        endcase
        // misaligned loads return zero.
        if (misalign) begin
            load_val = '0;
        end
    end

    // ========================================
    // result register
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata       <= '0;
            rdata_valid <= 1'b0;
            rmisalign   <= 1'b0;
        end else begin
            // valid is a single-cycle pulse per load.
            rdata_valid <= load_req;
            if (load_req) begin
                rdata     <= load_val;
                rmisalign <= misalign;
            end
        end
    end

endmodule

`default_nettype wire

//--- dmem_top.sv
`default_nettype none

module dmem_top #(
    parameter int ADDR_BITS = 10
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            en,
    input  logic                            we,
    input  dmem_pkg::dmem_op_e              op,
    input  logic [ADDR_BITS-1:0]            addr,
    input  logic [dmem_pkg::DATA_W-1:0]     wdata,
    input  logic [ADDR_BITS-3:0]            addr_dbg,
    output logic [dmem_pkg::DATA_W-1:0]     rdata,
    output logic                            rdata_valid,
    output logic                            rmisalign,
    output logic [dmem_pkg::DATA_W-1:0]     data_dbg
);

    logic [dmem_pkg::LANES-1:0]     lane_we;
    logic [dmem_pkg::DATA_W-1:0]    lane_wdata;
    logic [dmem_pkg::DATA_W-1:0]    rword;
    logic                           misalign;

    // store decode.
    store_lane_gen #(
        .ADDR_BITS  (ADDR_BITS)
    ) u_store_lane_gen (
        .en         (en),
        .we         (we),
        .op         (op),
        .addr       (addr),
        .wdata      (wdata),
        .lane_we    (lane_we),
        .lane_wdata (lane_wdata),
        .misalign   (misalign)
    );

    // byte banks.
    byte_lane_ram #(
        .ADDR_BITS  (ADDR_BITS)
    ) u_byte_lane_ram (
        .clk        (clk),
        .lane_we    (lane_we),
        .lane_wdata (lane_wdata),
        .waddr      (addr[ADDR_BITS-1:2]),
        .addr_dbg   (addr_dbg),
        .rword      (rword),
        .data_dbg   (data_dbg)
    );

    // load path.
    load_extract u_load_extract (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .we          (we),
        .op          (op),
        .byte_off    (addr[1:0]),
        .rword       (rword),
        .misalign    (misalign),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .rmisalign   (rmisalign)
    );

endmodule

`default_nettype wire

//--- dmem_checker.sv
`default_nettype none

module dmem_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    input  logic            we,
    input  logic [31:0]     rdata,
    input  logic            rdata_valid,
    input  logic            rmisalign,
    input  logic [31:0]     data_dbg
);

    int     n_checks = 0;
    int     n_errors = 0;
    logic   load_prev = 1'b0;
    logic   seen_valid = 1'b0;

    task automatic report_problem(input string msg);
        n_errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic compare_word(input string name, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("** Error: test %s, %s expected %h, actual %h",
                     name, what, expected, actual);
        end
    endtask

    // ========================================
    // sampling at the falling edge
    // ========================================

    always @(negedge clk) begin : watch
        string          name;
        logic [31:0]    exp_rdata;
        logic           exp_rchk;
        logic           exp_mis;
        if (!rst_n) begin
            load_prev  = 1'b0;
            seen_valid = 1'b0;
        end else begin
            if (load_prev) begin
                // a load was on the inputs during the previous cycle.
                if (tb_dmem.exp_name_q.size() == 0) begin
                    report_problem("a load was issued but no expected result was queued");
                end else begin
                    name      = tb_dmem.exp_name_q.pop_front();
                    exp_rdata = tb_dmem.exp_rdata_q.pop_front();
                    exp_rchk  = tb_dmem.exp_rchk_q.pop_front();
                    exp_mis   = tb_dmem.exp_mis_q.pop_front();
                    if (rdata_valid !== 1'b1) begin
                        report_problem($sformatf("test %s: no rdata_valid pulse after the load",
                                                 name));
                    end else begin
                        seen_valid = 1'b1;
                        if (exp_rchk) begin
                            compare_word(name, "rdata", exp_rdata, rdata);
                        end
                        compare_word(name, "rmisalign", 32'(exp_mis), 32'(rmisalign));
                    end
                end
            end else if (rdata_valid !== 1'b0) begin
                report_problem("rdata_valid pulsed without a load in the cycle before");
            end else if (!seen_valid && rdata !== '0) begin
                report_problem("rdata is not zero after reset and before the first load");
            end
            if (tb_dmem.cur_dbg_chk) begin
                compare_word(tb_dmem.cur_name, "data_dbg", tb_dmem.cur_dbg_exp, data_dbg);
            end
            load_prev = en && !we;
        end
    end

endmodule

`default_nettype wire

//--- tb_dmem.sv
`default_nettype none

module tb_dmem;

    localparam int ADDR_BITS = 10;
    localparam int PERIOD    = 8;
    localparam int DRIVE_DLY = 1;

    typedef struct packed {
        logic                   en;
        logic                   we;
        logic [2:0]             op;
        logic [ADDR_BITS-1:0]   addr;
        logic [31:0]            wdata;
        logic [ADDR_BITS-3:0]   addr_dbg;
        logic                   rchk;
        logic [31:0]            rexp;
        logic                   mis;
        logic                   dchk;
        logic [31:0]            dexp;
    } test_line_t;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   en;
    logic                   we;
    dmem_pkg::dmem_op_e     op;
    logic [ADDR_BITS-1:0]   addr;
    logic [31:0]            wdata;
    logic [ADDR_BITS-3:0]   addr_dbg;
    logic [31:0]            rdata;
    logic                   rdata_valid;
    logic                   rmisalign;
    logic [31:0]            data_dbg;

    test_line_t     lines_q[$];
    string          names_q[$];
    int             n_tests = 0;

    // expected load results, taken by the checker when rdata_valid pulses.
    string          exp_name_q[$];
    logic [31:0]    exp_rdata_q[$];
    logic           exp_rchk_q[$];
    logic           exp_mis_q[$];

    // debug word expected for the line now on the inputs.
    string          cur_name = "";
    logic           cur_dbg_chk = 1'b0;
    logic [31:0]    cur_dbg_exp = '0;

    always #(PERIOD / 2) clk = ~clk;

    dmem_top #(
        .ADDR_BITS   (ADDR_BITS)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .we          (we),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .addr_dbg    (addr_dbg),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .rmisalign   (rmisalign),
        .data_dbg    (data_dbg)
    );

    dmem_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .we          (we),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .rmisalign   (rmisalign),
        .data_dbg    (data_dbg)
    );

    // ========================================
    // test file parsing
    // ========================================

    task automatic load_tests(output int count);
        int             fd;
        int             got;
        int             v_en;
        int             v_we;
        int             v_op;
        int             v_mis;
        string          text;
        string          name;
        string          rexp_s;
        string          dexp_s;
        logic [31:0]    v_addr;
        logic [31:0]    v_wdata;
        logic [31:0]    v_dbg;
        logic [31:0]    v_rexp;
        logic [31:0]    v_dexp;
        test_line_t     l;
        count = 0;
        fd = $fopen("dmem_tests.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                text = "";
                void'($fgets(text, fd));
                got = $sscanf(text, "%s %d %d %d %h %h %h %s %d %s", name, v_en, v_we,
                              v_op, v_addr, v_wdata, v_dbg, rexp_s, v_mis, dexp_s);
                // comment lines and blank lines do not parse to ten fields.
                if (got == 10) begin
                    v_rexp = '0;
                    v_dexp = '0;
                    if (rexp_s != "-") begin
                        void'($sscanf(rexp_s, "%h", v_rexp));
                    end
                    if (dexp_s != "-") begin
                        void'($sscanf(dexp_s, "%h", v_dexp));
                    end
                    l.en       = v_en[0];
                    l.we       = v_we[0];
                    l.op       = v_op[2:0];
                    l.addr     = v_addr[ADDR_BITS-1:0];
                    l.wdata    = v_wdata;
                    l.addr_dbg = v_dbg[ADDR_BITS-3:0];
                    l.rchk     = (rexp_s != "-");
                    l.rexp     = v_rexp;
                    l.mis      = v_mis[0];
                    l.dchk     = (dexp_s != "-");
                    l.dexp     = v_dexp;
                    lines_q.push_back(l);
                    names_q.push_back(name);
                    count++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_line(input int i);
        test_line_t l;
        l = lines_q[i];
        @(posedge clk);
        #DRIVE_DLY;
        en          = l.en;
        we          = l.we;
        op          = dmem_pkg::dmem_op_e'(l.op);
        addr        = l.addr;
        wdata       = l.wdata;
        addr_dbg    = l.addr_dbg;
        cur_name    = names_q[i];
        cur_dbg_chk = l.dchk;
        cur_dbg_exp = l.dexp;
        if (l.en && !l.we) begin
            exp_name_q.push_back(names_q[i]);
            exp_rdata_q.push_back(l.rexp);
            exp_rchk_q.push_back(l.rchk);
            exp_mis_q.push_back(l.mis);
        end
    endtask

    // ========================================
    // stimulus and summary
    // ========================================

    initial begin : stimulus
        int n;
        rst_n    = 1'b0;
        en       = 1'b0;
        we       = 1'b0;
        op       = dmem_pkg::DM_OP_WD;
        addr     = '0;
        wdata    = '0;
        addr_dbg = '0;
        load_tests(n);
        if (n == 0) begin
            $display("no test lines could be read from dmem_tests.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            n_tests = n;
            repeat (8) @(posedge clk);
            #DRIVE_DLY;
            rst_n = 1'b1;
            for (int i = 0; i < n; i++) begin
                apply_line(i);
            end
            @(posedge clk);
            #DRIVE_DLY;
            en          = 1'b0;
            we          = 1'b0;
            cur_dbg_chk = 1'b0;
            repeat (2) @(posedge clk);
            @(negedge clk);
            // let the checker finish its sample of this edge first.
            #DRIVE_DLY;
            $display("tests %0d, checks %0d, errors %0d", n,
                     u_checker.n_checks, u_checker.n_errors);
            if (u_checker.n_errors == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

    initial begin : watchdog
        wait (n_tests > 0);
        #((n_tests + 20) * PERIOD);
        $display("timeout: the run did not end within %0d cycles", n_tests + 20);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dmem_tests.txt
# name en we op addr wdata addr_dbg exp_rdata exp_rmisalign exp_data_dbg (hex for addr and data)
# op 0 word, 1 half signed, 2 half unsigned, 3 byte signed, 4 byte unsigned; - is not checked
idle_reset     0 0 0 000 00000000 00 -        0 -
sw_w0          1 1 0 000 12345678 00 -        0 -
lw_w0          1 0 0 000 00000000 00 12345678 0 12345678
sw_w1          1 1 0 004 deadbeef 00 -        0 12345678
lw_w1          1 0 0 004 00000000 01 deadbeef 0 deadbeef
sw_w2          1 1 0 008 a5a5a5a5 01 -        0 deadbeef
sb_w2_b0       1 1 4 008 11223344 02 -        0 a5a5a5a5
sb_w2_b1       1 1 3 009 00000055 02 -        0 a5a5a544
sb_w2_b2       1 1 4 00a ffffff66 02 -        0 a5a55544
sb_w2_b3       1 1 3 00b 00000077 02 -        0 a5665544
lw_w2_bytes    1 0 0 008 00000000 02 77665544 0 77665544
sw_w3          1 1 0 00c 01020304 02 -        0 77665544
sh_w3_lo       1 1 2 00c abcd8765 03 -        0 01020304
sh_w3_hi       1 1 1 00e 0000f00d 03 -        0 01028765
lw_w3_halves   1 0 0 00c 00000000 03 f00d8765 0 f00d8765
lb_s_b1        1 0 3 00d 00000000 03 ffffff87 0 f00d8765
lbu_b1         1 0 4 00d 00000000 03 00000087 0 f00d8765
lb_s_b0        1 0 3 00c 00000000 03 00000065 0 f00d8765
lb_s_b3        1 0 3 00f 00000000 03 fffffff0 0 f00d8765
lbu_b3         1 0 4 00f 00000000 03 000000f0 0 f00d8765
lh_s_lo        1 0 1 00c 00000000 03 ffff8765 0 f00d8765
lhu_lo         1 0 2 00c 00000000 03 00008765 0 f00d8765
lh_s_hi        1 0 1 00e 00000000 03 fffff00d 0 f00d8765
lhu_hi         1 0 2 00e 00000000 03 0000f00d 0 f00d8765
lb_s_b2        1 0 3 00e 00000000 03 0000000d 0 f00d8765
sw_mis1        1 1 0 001 ffffffff 00 -        0 12345678
sw_mis2        1 1 0 002 ffffffff 00 -        0 12345678
sw_mis3        1 1 0 003 ffffffff 00 -        0 12345678
sh_mis1        1 1 2 001 0000ffff 00 -        0 12345678
sh_mis3        1 1 1 003 0000ffff 00 -        0 12345678
lw_mis_chk     1 0 0 000 00000000 00 12345678 0 12345678
lw_mis1        1 0 0 001 00000000 00 00000000 1 12345678
lw_mis2        1 0 0 002 00000000 00 00000000 1 12345678
lh_mis1        1 0 1 005 00000000 01 00000000 1 deadbeef
lhu_mis3       1 0 2 007 00000000 01 00000000 1 deadbeef
lw_after_mis   1 0 0 004 00000000 01 deadbeef 0 deadbeef
sw_dis         0 1 0 004 0badf00d 01 -        0 deadbeef
lw_dis         0 0 0 004 00000000 01 -        0 deadbeef
sb_dis         0 1 4 008 000000ff 02 -        0 77665544
lw_w1_chk      1 0 0 004 00000000 01 deadbeef 0 deadbeef
lw_w2_chk      1 0 0 008 00000000 02 77665544 0 77665544
sw_op5         1 1 5 008 ffffffff 02 -        0 77665544
lw_op6         1 0 6 008 00000000 02 00000000 0 77665544
lb_s_w1        1 0 3 005 00000000 01 ffffffbe 0 deadbeef
lw_last        1 0 0 008 00000000 02 77665544 0 77665544

//--- vlog.f
dmem_pkg.sv
store_lane_gen.sv
byte_lane_ram.sv
load_extract.sv
dmem_top.sv
dmem_checker.sv
tb_dmem.sv

//--- Makefile
# Verilator build and run of the data memory testbench.

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and search the log for the verdict"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --top-module tb_dmem -f vlog.f
	./obj_dir/Vtb_dmem | tee $(LOG)
	@if grep -q "^TEST OK$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
